// ==== Bender.yml ====
package:
  name: dcache

sources:
  - source/dcache_pkg.sv
  - source/cache_mem_if.sv
  - source/dcache.sv
  - source/mem_bridge.sv
  - source/dcache_top.sv
  - target: test
    files:
      - test/dcache_tb.sv

// ==== compile.f ====
source/dcache_pkg.sv
source/cache_mem_if.sv
source/dcache.sv
source/mem_bridge.sv
source/dcache_top.sv
test/dcache_tb.sv

// ==== source/cache_mem_if.sv ====
`timescale 1ns/1ps

interface cache_mem_if;
    import dcache_pkg::*;

    // cache side strobes and write data
    logic  dREN;
    logic  dWEN;
    word_t daddr;
    word_t dstore;

    // bridge side read data and wait
    word_t dload;
    logic  dwait;

    modport cache (
        output dREN, dWEN, daddr, dstore,
        input  dload, dwait
    );

    modport bridge (
        input  dREN, dWEN, daddr, dstore,
        output dload, dwait
    );

endinterface

// ==== source/dcache.sv ====
`timescale 1ns/1ps

module dcache #(
    parameter dcache_pkg::word_t HIT_COUNT_ADDR = 32'h3100
) (
    input  logic              CLK,
    input  logic              n_rst,
    input  logic              dmem_ren,
    input  logic              dmem_wen,
    input  logic              halt,
    input  dcache_pkg::word_t dmem_addr,
    input  dcache_pkg::word_t dmem_store,
    output logic              dhit,
    output logic              flushed,
    output dcache_pkg::word_t dmem_load,
    cache_mem_if.cache        mem
);
    import dcache_pkg::*;

    localparam int SCAN_W = $clog2(SETS * WAYS);
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(SETS * WAYS - 1);

    typedef enum logic [3:0] {
        s_idle,
        s_wb0,
        s_wb1,
        s_fill0,
        s_fill1,
        s_flush_scan,
        s_flush0,
        s_flush1,
        s_cnt_write,
        s_done
    } state_t;

    state_t state;
    state_t next_state;

    dcache_frame_t lines [WAYS][SETS];
    logic [SETS-1:0] lru;
    word_t hit_count;
    logic filled;
    logic [SCAN_W-1:0] scan_ptr;

    dcache_addr_u req;
    dcache_addr_u ev_addr;
    dcache_frame_t ev_line;
    idx_t idx;
    idx_t scan_set;
    idx_t ev_set;
    logic scan_way;
    logic ev_way;
    logic ev_word;
    logic req_active;
    logic hit0;
    logic hit1;
    logic hit;
    logic hit_way;
    logic victim;
    logic victim_dirty;
    logic flush_dirty;
    word_t fill_addr;

    // field view for lookup
    assign req.raw = dmem_addr;
    assign idx = req.f.idx;

    assign req_active = dmem_ren | dmem_wen;

    assign hit0 = lines[0][idx].valid && (lines[0][idx].tag == req.f.tag);
    assign hit1 = lines[1][idx].valid && (lines[1][idx].tag == req.f.tag);
    assign hit = hit0 | hit1;
    assign hit_way = hit1;

    // lru bit names the way to replace
    assign victim = lru[idx];
    assign victim_dirty = lines[victim][idx].valid && lines[victim][idx].dirty;

    // flush walks every set and way in turn
    assign scan_set = scan_ptr[SCAN_W-1:1];
    assign scan_way = scan_ptr[0];
    assign flush_dirty = lines[scan_way][scan_set].valid && lines[scan_way][scan_set].dirty;

    assign dhit = (state == s_idle) && req_active && hit;
    assign dmem_load = lines[hit_way][idx].data[req.f.blkoff];
    assign flushed = (state == s_done);

    // block base from the raw request word
    assign fill_addr = {req.raw[31:3], state == s_fill1, 2'b00};

    // line being written back, either the miss victim or the flush cursor
    always_comb begin
        if (state == s_flush0 || state == s_flush1) begin
            ev_way = scan_way;
            ev_set = scan_set;
        end else begin
            ev_way = victim;
            ev_set = idx;
        end
        ev_word = (state == s_wb1) || (state == s_flush1);
        ev_line = lines[ev_way][ev_set];
        ev_addr.f.tag = ev_line.tag;
        ev_addr.f.idx = ev_set;
        ev_addr.f.blkoff = ev_word;
        ev_addr.f.bytoff = 2'b00;
    end

    always_comb begin
        next_state = state;
        case (state)
            s_idle: begin
                if (halt) begin
                    next_state = s_flush_scan;
                end else if (req_active && !hit) begin
                    next_state = victim_dirty ? s_wb0 : s_fill0;
                end
            end
            s_wb0: begin
                if (!mem.dwait) begin
                    next_state = s_wb1;
                end
            end
            s_wb1: begin
                if (!mem.dwait) begin
                    next_state = s_fill0;
                end
            end
            s_fill0: begin
                if (!mem.dwait) begin
                    next_state = s_fill1;
                end
            end
            s_fill1: begin
                if (!mem.dwait) begin
                    next_state = s_idle;
                end
            end
            s_flush_scan: begin
                if (flush_dirty) begin
                    next_state = s_flush0;
                end else if (scan_ptr == SCAN_LAST) begin
                    next_state = s_cnt_write;
                end
            end
            s_flush0: begin
                if (!mem.dwait) begin
                    next_state = s_flush1;
                end
            end
            s_flush1: begin
                // line is clean now, scan picks it up again and moves on
                if (!mem.dwait) begin
                    next_state = s_flush_scan;
                end
            end
            s_cnt_write: begin
                if (!mem.dwait) begin
                    next_state = s_done;
                end
            end
            default: begin
                next_state = s_done;
            end
        endcase
    end

    // memory strobes held until dwait drops
    always_comb begin
        mem.dREN = 1'b0;
        mem.dWEN = 1'b0;
        mem.daddr = '0;
        mem.dstore = '0;
        case (state)
            s_wb0, s_wb1, s_flush0, s_flush1: begin
                mem.dWEN = 1'b1;
                mem.daddr = ev_addr.raw;
                mem.dstore = ev_line.data[ev_word];
            end
            s_fill0, s_fill1: begin
                mem.dREN = 1'b1;
                mem.daddr = fill_addr;
            end
            s_cnt_write: begin
                mem.dWEN = 1'b1;
                mem.daddr = HIT_COUNT_ADDR;
                mem.dstore = hit_count;
            end
            default: begin
                mem.dREN = 1'b0;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            state <= s_idle;
            lru <= '0;
            hit_count <= '0;
            filled <= 1'b0;
            scan_ptr <= '0;
            for (int w = 0; w < WAYS; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    lines[w][s] <= '0;
                end
            end
        end else begin
            state <= next_state;
            case (state)
                s_idle: begin
                    if (dhit) begin
                        lru[idx] <= ~hit_way;
                        filled <= 1'b0;
                        // the hit that ends a miss is not counted
                        if (!filled) begin
                            hit_count <= hit_count + 1'b1;
                        end
                        if (dmem_wen) begin
                            lines[hit_way][idx].dirty <= 1'b1;
                            lines[hit_way][idx].data[req.f.blkoff] <= dmem_store;
                        end
                    end
                end
                s_fill0: begin
                    if (!mem.dwait) begin
                        lines[victim][idx].data[0] <= mem.dload;
                    end
                end
                s_fill1: begin
                    if (!mem.dwait) begin
                        lines[victim][idx].valid <= 1'b1;
                        lines[victim][idx].dirty <= 1'b0;
                        lines[victim][idx].tag <= req.f.tag;
                        lines[victim][idx].data[1] <= mem.dload;
                        filled <= 1'b1;
                    end
                end
                s_flush_scan: begin
                    // clean or empty lines are dropped as the scan passes
                    if (!flush_dirty) begin
                        lines[scan_way][scan_set].valid <= 1'b0;
                        scan_ptr <= scan_ptr + 1'b1;
                    end
                end
                s_flush1: begin
                    if (!mem.dwait) begin
                        lines[scan_way][scan_set].dirty <= 1'b0;
                    end
                end
                default: begin
                    filled <= filled;
                end
            endcase
        end
    end

endmodule

// ==== source/dcache_pkg.sv ====
package dcache_pkg;

    // data and address word
    typedef logic [31:0] word_t;

    // address tag above index and offsets
    typedef logic [25:0] tag_t;

    // set index
    typedef logic [2:0] idx_t;

    // cache geometry
    localparam int SETS = 8;
    localparam int WAYS = 2;

    // byte address split for lookup
    typedef struct packed {
        tag_t       tag;
        idx_t       idx;
        logic       blkoff;
        logic [1:0] bytoff;
    } dcache_addr_t;

    // same address seen as fields or as a raw word
    typedef union packed {
        word_t        raw;
        dcache_addr_t f;
    } dcache_addr_u;

    // one line of a way
    typedef struct packed {
        logic            valid;
        logic            dirty;
        tag_t            tag;
        word_t [1:0]     data;
    } dcache_frame_t;

endpackage

// ==== source/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top #(
    parameter dcache_pkg::word_t HIT_COUNT_ADDR = 32'h3100
) (
    input  logic              CLK,
    input  logic              n_rst,

    // datapath side
    input  logic              dmem_ren,
    input  logic              dmem_wen,
    input  logic              halt,
    input  dcache_pkg::word_t dmem_addr,
    input  dcache_pkg::word_t dmem_store,
    output logic              dhit,
    output logic              flushed,
    output dcache_pkg::word_t dmem_load,

    // external memory bus
    output logic              mem_req,
    output logic              mem_wen,
    output dcache_pkg::word_t mem_addr,
    output dcache_pkg::word_t mem_wdata,
    input  logic              mem_ack,
    input  dcache_pkg::word_t mem_rdata
);

    cache_mem_if cm_if ();

    dcache #(
        .HIT_COUNT_ADDR (HIT_COUNT_ADDR)
    ) dcache_i (
        .CLK        (CLK),
        .n_rst      (n_rst),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .halt       (halt),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .dhit       (dhit),
        .flushed    (flushed),
        .dmem_load  (dmem_load),
        .mem        (cm_if.cache)
    );

    mem_bridge mem_bridge_i (
        .CLK       (CLK),
        .n_rst     (n_rst),
        .mem       (cm_if.bridge),
        .mem_req   (mem_req),
        .mem_wen   (mem_wen),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

// ==== source/mem_bridge.sv ====
`timescale 1ns/1ps

module mem_bridge (
    input  logic              CLK,
    input  logic              n_rst,
    cache_mem_if.bridge       mem,
    output logic              mem_req,
    output logic              mem_wen,
    output dcache_pkg::word_t mem_addr,
    output dcache_pkg::word_t mem_wdata,
    input  logic              mem_ack,
    input  dcache_pkg::word_t mem_rdata
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        b_idle,
        b_busy,
        b_release
    } bridge_state_t;

    bridge_state_t state;
    word_t rdata_q;

    // request is on the bus for the whole busy state
    assign mem_req = (state == b_busy);

    // one low cycle of dwait per finished word
    assign mem.dwait = (state != b_release);
    assign mem.dload = rdata_q;

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            state <= b_idle;
            mem_wen <= 1'b0;
        end else begin
            case (state)
                b_idle: begin
                    if (mem.dREN || mem.dWEN) begin
                        mem_wen <= mem.dWEN;
                        state <= b_busy;
                    end
                end
                b_busy: begin
                    if (mem_ack) begin
                        state <= b_release;
                    end
                end
                default: begin
                    // cache still holds its strobe here, nothing new starts
                    state <= b_idle;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge CLK) begin
        if (state == b_idle && (mem.dREN || mem.dWEN)) begin
            mem_addr <= mem.daddr;
            mem_wdata <= mem.dstore;
        end
        if (state == b_busy && mem_ack) begin
            rdata_q <= mem_rdata;
        end
    end

endmodule

// ==== test/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam word_t COUNT_ADDR = 32'h3100;
    localparam int OP_READ = 0;
    localparam int OP_WRITE = 1;
    localparam int OP_HALT = 2;

    typedef struct {
        int    op;
        word_t addr;
        word_t wdata;
        word_t exp;
    } entry_t;

    logic  CLK, n_rst;
    logic  dmem_ren, dmem_wen, halt;
    word_t dmem_addr, dmem_store, dmem_load;
    logic  dhit, flushed;
    logic  mem_req, mem_wen, mem_ack;
    word_t mem_addr, mem_wdata, mem_rdata;

    integer seed = 82820;
    entry_t tbl [$];
    bit     table_built;
    int     write_count;
    word_t  last_wr [word_t];
    word_t  mem_img [word_t];
    word_t  ref_mem [word_t];
    word_t  exp_waddr [$];
    word_t  exp_wdata [$];

    // reference cache
    dcache_frame_t   ref_lines [WAYS][SETS];
    logic [SETS-1:0] ref_lru;
    word_t           ref_hits;

    dcache_top #(.HIT_COUNT_ADDR(COUNT_ADDR)) dcache_top_i (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_fail($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // expected data is the last store or else the address itself
    task automatic add_entry(input int op, input word_t a, input word_t d);
        entry_t e;
        e.op = op;
        e.addr = a;
        e.wdata = d;
        e.exp = last_wr.exists(a) ? last_wr[a] : a;
        if (op == OP_WRITE) begin
            last_wr[a] = d;
        end
        tbl.push_back(e);
    endtask

    task automatic build_table();
        word_t a;
        // cold sets and then hits in the same blocks
        add_entry(OP_READ, 32'h000, '0);
        add_entry(OP_READ, 32'h008, '0);
        add_entry(OP_READ, 32'h010, '0);
        add_entry(OP_READ, 32'h004, '0);
        add_entry(OP_READ, 32'h000, '0);
        add_entry(OP_WRITE, 32'h008, 32'hcafe_0008);
        add_entry(OP_READ, 32'h008, '0);
        add_entry(OP_WRITE, 32'h014, 32'h5a5a_0014);
        add_entry(OP_READ, 32'h014, '0);
        // three blocks in set 0 with a dirty victim
        add_entry(OP_WRITE, 32'h000, 32'h1111_0000);
        add_entry(OP_READ, 32'h040, '0);
        add_entry(OP_READ, 32'h080, '0);
        add_entry(OP_READ, 32'h000, '0);
        // stored word of set 1 evicted and refilled
        add_entry(OP_READ, 32'h048, '0);
        add_entry(OP_READ, 32'h088, '0);
        add_entry(OP_READ, 32'h008, '0);
        for (int k = 0; k < 48; k++) begin
            a = ({$random(seed)} % 64) * 4;
            if (($random(seed) & 1) != 0) begin
                add_entry(OP_WRITE, a, $random(seed));
            end else begin
                add_entry(OP_READ, a, '0);
            end
        end
        add_entry(OP_HALT, '0, '0);
    endtask

    function automatic word_t ref_read(input word_t a);
        return ref_mem.exists(a) ? ref_mem[a] : a;
    endfunction

    task automatic expect_write(input word_t a, input word_t d);
        exp_waddr.push_back(a);
        exp_wdata.push_back(d);
        ref_mem[a] = d;
    endtask

    task automatic model_access(input bit wr, input word_t a, input word_t d, output bit hit);
        idx_t s;
        tag_t t;
        int   way;
        s = a[5:3];
        t = a[31:6];
        hit = 1'b0;
        way = ref_lru[s];
        for (int w = 0; w < WAYS; w++) begin
            if (ref_lines[w][s].valid && ref_lines[w][s].tag == t) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (hit) begin
            ref_hits++;
        end else begin
            if (ref_lines[way][s].valid && ref_lines[way][s].dirty) begin
                for (int b = 0; b < 2; b++) begin
                    expect_write({ref_lines[way][s].tag, s, b[0], 2'b00},
                                 ref_lines[way][s].data[b]);
                end
            end
            for (int b = 0; b < 2; b++) begin
                ref_lines[way][s].data[b] = ref_read({a[31:3], b[0], 2'b00});
            end
            ref_lines[way][s].valid = 1'b1;
            ref_lines[way][s].dirty = 1'b0;
            ref_lines[way][s].tag = t;
        end
        ref_lru[s] = (way == 0);
        if (wr) begin
            ref_lines[way][s].data[a[2]] = d;
            ref_lines[way][s].dirty = 1'b1;
        end
    endtask

    // flush order is set by set with way 0 before way 1
    task automatic model_halt();
        idx_t s;
        int   w;
        for (int p = 0; p < SETS * WAYS; p++) begin
            s = idx_t'(p / 2);
            w = p % 2;
            if (ref_lines[w][s].valid && ref_lines[w][s].dirty) begin
                for (int b = 0; b < 2; b++) begin
                    expect_write({ref_lines[w][s].tag, s, b[0], 2'b00}, ref_lines[w][s].data[b]);
                end
            end
            ref_lines[w][s].valid = 1'b0;
        end
        expect_write(COUNT_ADDR, ref_hits);
    endtask

    task automatic serve_bus();
        if (mem_wen) begin
            write_count++;
            $display("write %h <= %h", mem_addr, mem_wdata);
            if (exp_waddr.size() == 0) begin
                stop_fail($sformatf("unexpected memory write to %h", mem_addr));
            end else begin
                check("mem_addr", mem_addr, exp_waddr.pop_front());
                check("mem_wdata", mem_wdata, exp_wdata.pop_front());
                mem_img[mem_addr] = mem_wdata;
            end
        end else begin
            if (exp_waddr.size() != 0) begin
                stop_fail("fill read started before the dirty victim was written back");
            end else begin
                mem_rdata = mem_img.exists(mem_addr) ? mem_img[mem_addr] : mem_addr;
            end
        end
    endtask

    // external memory acks 1 to 4 cycles into a request
    initial begin : memory_model
        int lat;
        lat = -1;
        mem_ack = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge CLK);
            #1;
            mem_ack = 1'b0;
            if (mem_req) begin
                if (lat < 0) begin
                    lat = {$random(seed)} % 4;
                end
                if (lat == 0) begin
                    mem_ack = 1'b1;
                    serve_bus();
                end
                lat--;
            end
        end
    end

    initial begin : watchdog
        wait (table_built);
        repeat (tbl.size() * 40 + 2000) @(posedge CLK);
        stop_fail("timeout: the run hung waiting for dhit or flushed");
    end

    initial begin : main
        entry_t e;
        bit     exp_hit;
        n_rst = 1'b0;
        dmem_ren = 1'b0;
        dmem_wen = 1'b0;
        halt = 1'b0;
        dmem_addr = '0;
        dmem_store = '0;
        ref_lru = '0;
        ref_hits = '0;
        write_count = 0;
        for (int w = 0; w < WAYS; w++) begin
            for (int s = 0; s < SETS; s++) begin
                ref_lines[w][s] = '0;
            end
        end
        build_table();
        table_built = 1'b1;
        repeat (10) @(posedge CLK);
        #1;
        n_rst = 1'b1;
        @(negedge CLK);
        check("dhit", dhit, 0);
        check("mem_req", mem_req, 0);
        check("mem_wen", mem_wen, 0);
        check("flushed", flushed, 0);
        foreach (tbl[i]) begin
            e = tbl[i];
            @(posedge CLK);
            #1;
            if (e.op == OP_HALT) begin
                dmem_ren = 1'b0;
                dmem_wen = 1'b0;
                model_halt();
                halt = 1'b1;
                do begin
                    @(negedge CLK);
                end while (!flushed);
            end else begin
                model_access(e.op == OP_WRITE, e.addr, e.wdata, exp_hit);
                dmem_ren = (e.op == OP_READ);
                dmem_wen = (e.op == OP_WRITE);
                dmem_addr = e.addr;
                dmem_store = e.wdata;
                @(negedge CLK);
                check("dhit", dhit, exp_hit);
                while (!dhit) begin
                    @(negedge CLK);
                end
                if (e.op == OP_READ) begin
                    check("dmem_load", dmem_load, e.exp);
                end
            end
        end
        // flushed holds until reset
        repeat (4) begin
            @(negedge CLK);
            check("flushed", flushed, 1);
        end
        if (exp_waddr.size() != 0) begin
            stop_fail($sformatf("%0d expected memory writes never happened", exp_waddr.size()));
        end else begin
            $display("%0d memory writes checked", write_count);
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule
